// ==== src/amb_pkg.sv ====
// ALU islem kodlari ve kaydirma sabiti; ALU, cozucu ve ust modul tarafindan import edilir
package amb_pkg;

    // ALU islemleri
    typedef enum logic [3:0] {
        AMB_TOPLAMA = 4'd0,
        AMB_CIKARMA = 4'd1,
        AMB_XOR     = 4'd2,
        AMB_OR      = 4'd3,
        AMB_AND     = 4'd4,
        AMB_SLL     = 4'd5,
        AMB_SRL     = 4'd6,
        AMB_SRA     = 4'd7,
        AMB_SLT     = 4'd8,
        AMB_SLTU    = 4'd9,
        AMB_GECIR   = 4'd10
    } amb_islem_t;

    // Ikinci degerin alt bitlerinden alinan kaydirma miktari
    localparam int AMB_KAYDIRMA_GENISLIGI = 5;

endpackage

// ==== src/buyruk_pkg.sv ====
// RV32I opcode/funct sabitleri ve buyruk sozcugunun R, I, U bicimleri; cozucu ve denetleyici kullanir
package buyruk_pkg;

    // R bicimi
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_bicim_t;

    // I bicimi
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_bicim_t;

    // U bicimi
    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_bicim_t;

    // Ayni 32 bitlik sozcugun uc gorunumu
    typedef union packed {
        r_bicim_t r_bicim;
        i_bicim_t i_bicim;
        u_bicim_t u_bicim;
    } buyruk_t;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;

    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // SUB ve SRA icin bit 5 set
    localparam logic [6:0] F7_TEMEL = 7'b0000000;
    localparam logic [6:0] F7_ALT   = 7'b0100000;

endpackage

// ==== src/carry_lookahead_toplayici.sv ====
// 4 bitlik ileri bakan gruplardan kurulan toplayici; ALU icinde toplama ve cikarma icin kullanilir
`timescale 1ns/1ns

module carry_lookahead_toplayici #(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0] deger1_i,
    input  logic [XLEN-1:0] deger2_i,
    input  logic            elde_i,
    output logic [XLEN-1:0] sonuc_o
);
    localparam int GRUP_SAYISI = XLEN / 4;

    logic [XLEN-1:0]        g;
    logic [XLEN-1:0]        p;
    logic [XLEN-1:0]        elde;
    logic [GRUP_SAYISI-1:0] grup_elde;

    // Bit bazinda uretme ve yayma
    assign g = deger1_i & deger2_i;
    assign p = deger1_i ^ deger2_i;

    assign grup_elde[0] = elde_i;

    for (genvar i = 0; i < GRUP_SAYISI; i++) begin : grup
        localparam int T = 4 * i;

        // Grup ici eldeler dogrudan grup girisinden
        assign elde[T]   = grup_elde[i];
        assign elde[T+1] = g[T] | (p[T] & grup_elde[i]);
        assign elde[T+2] = g[T+1] | (p[T+1] & g[T]) | (p[T+1] & p[T] & grup_elde[i]);
        assign elde[T+3] = g[T+2] | (p[T+2] & g[T+1]) | (p[T+2] & p[T+1] & g[T])
                         | (p[T+2] & p[T+1] & p[T] & grup_elde[i]);

        // Son grubun cikis eldesi atilir
        if (i < GRUP_SAYISI - 1) begin : zincir
            assign grup_elde[i+1] = g[T+3]
                                  | (p[T+3] & g[T+2])
                                  | (p[T+3] & p[T+2] & g[T+1])
                                  | (p[T+3] & p[T+2] & p[T+1] & g[T])
                                  | (p[T+3] & p[T+2] & p[T+1] & p[T] & grup_elde[i]);
        end
    end

    assign sonuc_o = p ^ elde;

endmodule

// ==== src/aritmetik_mantik_birimi.sv ====
// Kombinasyonel ALU; cozulen islem koduna gore toplama, mantik, kaydirma, karsilastirma sonucu verir
`timescale 1ns/1ns

module aritmetik_mantik_birimi import amb_pkg::*; #(
    parameter int XLEN = 32
) (
    input  amb_islem_t      islem_i,
    input  logic [XLEN-1:0] deger1_i,
    input  logic [XLEN-1:0] deger2_i,
    output logic [XLEN-1:0] sonuc_o
);
    logic                              cikarma;
    logic [XLEN-1:0]                   deger2_cla;
    logic [XLEN-1:0]                   sonuc_cla;
    logic [AMB_KAYDIRMA_GENISLIGI-1:0] kaydirma;
    logic                              kucuk;
    logic                              kucuk_isaretsiz;

    // Cikarma icin ters deger ve elde girisi 1
    assign cikarma    = (islem_i == AMB_CIKARMA);
    assign deger2_cla = cikarma ? ~deger2_i : deger2_i;

    carry_lookahead_toplayici #(
        .XLEN(XLEN)
    ) cla (
        .deger1_i(deger1_i),
        .deger2_i(deger2_cla),
        .elde_i  (cikarma),
        .sonuc_o (sonuc_cla)
    );

    assign kaydirma = deger2_i[AMB_KAYDIRMA_GENISLIGI-1:0];

    assign kucuk           = $signed(deger1_i) < $signed(deger2_i);
    assign kucuk_isaretsiz = deger1_i < deger2_i;

    always_comb begin
        case (islem_i)
            AMB_TOPLAMA,
            AMB_CIKARMA: sonuc_o = sonuc_cla;
            AMB_XOR:     sonuc_o = deger1_i ^ deger2_i;
            AMB_OR:      sonuc_o = deger1_i | deger2_i;
            AMB_AND:     sonuc_o = deger1_i & deger2_i;
            AMB_SLL:     sonuc_o = deger1_i << kaydirma;
            AMB_SRL:     sonuc_o = deger1_i >> kaydirma;
            // Isaret biti kopyalanir
            AMB_SRA:     sonuc_o = $unsigned($signed(deger1_i) >>> kaydirma);
            AMB_SLT:     sonuc_o = {{(XLEN-1){1'b0}}, kucuk};
            AMB_SLTU:    sonuc_o = {{(XLEN-1){1'b0}}, kucuk_isaretsiz};
            AMB_GECIR:   sonuc_o = deger2_i;
            default:     sonuc_o = '0;
        endcase
    end

endmodule

// ==== src/buyruk_cozucu.sv ====
// Tutulan buyruk sozcugunu ALU islemine, ikinci degere ve gecersiz bayragina cozer
`timescale 1ns/1ns

module buyruk_cozucu import amb_pkg::*, buyruk_pkg::*; (
    input  buyruk_t     buyruk_i,
    input  logic [31:0] deger2_i,
    output amb_islem_t  islem_o,
    output logic [31:0] ikinci_deger_o,
    output logic        gecersiz_o
);
    logic [6:0] ust_alan;
    logic       temel;
    logic       alt;
    logic [2:0] f3_r;
    logic [2:0] f3_i;

    // funct3 ve alt secimden islem kodu
    function automatic amb_islem_t f3_islem(input logic [2:0] f3, input logic alt_secim);
        amb_islem_t sonuc;
        case (f3)
            F3_ADD_SUB: sonuc = alt_secim ? AMB_CIKARMA : AMB_TOPLAMA;
            F3_SLL:     sonuc = AMB_SLL;
            F3_SLT:     sonuc = AMB_SLT;
            F3_SLTU:    sonuc = AMB_SLTU;
            F3_XOR:     sonuc = AMB_XOR;
            F3_SRL_SRA: sonuc = alt_secim ? AMB_SRA : AMB_SRL;
            F3_OR:      sonuc = AMB_OR;
            F3_AND:     sonuc = AMB_AND;
            default:    sonuc = AMB_TOPLAMA;
        endcase
        return sonuc;
    endfunction

    // funct7 ya da kaydirma anlik degerinin ust 7 biti
    assign ust_alan = buyruk_i.r_bicim.funct7;
    assign temel    = (ust_alan == F7_TEMEL);
    assign alt      = (ust_alan == F7_ALT);
    assign f3_r     = buyruk_i.r_bicim.funct3;
    assign f3_i     = buyruk_i.i_bicim.funct3;

    always_comb begin
        islem_o        = AMB_TOPLAMA;
        ikinci_deger_o = deger2_i;
        gecersiz_o     = 1'b0;
        case (buyruk_i.r_bicim.opcode)
            OPC_OP: begin
                islem_o    = f3_islem(f3_r, alt);
                // ALT yalnizca SUB ve SRA icin
                gecersiz_o = !(temel || (alt && (f3_r == F3_ADD_SUB || f3_r == F3_SRL_SRA)));
            end
            OPC_OP_IMM: begin
                ikinci_deger_o = {{20{buyruk_i.i_bicim.imm[11]}}, buyruk_i.i_bicim.imm};
                // ADDI hicbir zaman cikarma degil
                islem_o = f3_islem(f3_i, alt && (f3_i == F3_SRL_SRA));
                if (f3_i == F3_SLL) begin
                    gecersiz_o = !temel;
                end else if (f3_i == F3_SRL_SRA) begin
                    gecersiz_o = !(temel || alt);
                end
            end
            OPC_LUI: begin
                islem_o        = AMB_GECIR;
                ikinci_deger_o = {buyruk_i.u_bicim.imm, 12'h000};
            end
            default: begin
                gecersiz_o = 1'b1;
            end
        endcase
    end

endmodule

// ==== src/yurutme_denetleyici.sv ====
// Dort fazli req/ack el sikisma FSM'i; girisleri tutar, sonucu kaydeder ve ack surer
`timescale 1ns/1ns

module yurutme_denetleyici import buyruk_pkg::*; (
    input  logic        clk_i,
    input  logic        rst_n_i,
    input  logic        req_i,
    output logic        ack_o,
    input  buyruk_t     buyruk_i,
    input  logic [31:0] deger1_i,
    input  logic [31:0] deger2_i,
    output buyruk_t     buyruk_o,
    output logic [31:0] deger1_o,
    output logic [31:0] deger2_o,
    input  logic [31:0] amb_sonuc_i,
    input  logic        gecersiz_i,
    output logic [31:0] sonuc_o,
    output logic        gecersiz_o
);
    typedef enum logic [1:0] {
        BOSTA,
        HESAPLA,
        BEKLE
    } durum_t;

    durum_t      durum_q;
    logic        ack_q;
    logic [31:0] sonuc_q;
    logic        gecersiz_q;
    buyruk_t     buyruk_q;
    logic [31:0] deger1_q;
    logic [31:0] deger2_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            durum_q    <= BOSTA;
            ack_q      <= 1'b0;
            sonuc_q    <= '0;
            gecersiz_q <= 1'b0;
        end else begin
            case (durum_q)
                BOSTA: begin
                    if (req_i) begin
                        durum_q <= HESAPLA;
                    end
                end
                HESAPLA: begin
                    sonuc_q    <= gecersiz_i ? '0 : amb_sonuc_i;
                    gecersiz_q <= gecersiz_i;
                    ack_q      <= 1'b1;
                    durum_q    <= BEKLE;
                end
                BEKLE: begin
                    // req dusene kadar cikislar sabit
                    if (!req_i) begin
                        ack_q   <= 1'b0;
                        durum_q <= BOSTA;
                    end
                end
                default: durum_q <= BOSTA;
            endcase
        end
    end

    // Istek kabul edildiginde girisler tutulur
    always_ff @(posedge clk_i) begin
        if (durum_q == BOSTA && req_i) begin
            buyruk_q <= buyruk_i;
            deger1_q <= deger1_i;
            deger2_q <= deger2_i;
        end
    end

    assign ack_o      = ack_q;
    assign sonuc_o    = sonuc_q;
    assign gecersiz_o = gecersiz_q;
    assign buyruk_o   = buyruk_q;
    assign deger1_o   = deger1_q;
    assign deger2_o   = deger2_q;

    // ack yalnizca acik bir istege cevap olarak yukselir
    a_ack_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $rose(ack_o) |-> $past(req_i));

    a_buyruk_sabit: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ack_o |=> (!ack_o || $stable(buyruk_q)));

    // Cozucu, ALU ve toplayici zincirinin ADD/SUB sonucu
    a_topla_cikar: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        ($rose(ack_o) && !gecersiz_o && buyruk_q.r_bicim.opcode == OPC_OP
            && buyruk_q.r_bicim.funct3 == F3_ADD_SUB)
        |-> (sonuc_o == ((buyruk_q.r_bicim.funct7 == F7_ALT) ? deger1_q - deger2_q
                                                             : deger1_q + deger2_q)));

endmodule

// ==== src/yurutme_birimi.sv ====
// Yurutme biriminin ust modulu; denetleyici, cozucu ve ALU'yu baglar, veri genisligini belirler
`timescale 1ns/1ns

module yurutme_birimi import amb_pkg::*, buyruk_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            req_i,
    input  buyruk_t         buyruk_i,
    input  logic [XLEN-1:0] deger1_i,
    input  logic [XLEN-1:0] deger2_i,
    output logic            ack_o,
    output logic [XLEN-1:0] sonuc_o,
    output logic            gecersiz_o
);
    buyruk_t         buyruk_q;
    logic [XLEN-1:0] deger1_q;
    logic [XLEN-1:0] deger2_q;
    amb_islem_t      islem;
    logic [XLEN-1:0] ikinci_deger;
    logic            gecersiz;
    logic [XLEN-1:0] amb_sonuc;

    yurutme_denetleyici denetleyici (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .req_i      (req_i),
        .ack_o      (ack_o),
        .buyruk_i   (buyruk_i),
        .deger1_i   (deger1_i),
        .deger2_i   (deger2_i),
        .buyruk_o   (buyruk_q),
        .deger1_o   (deger1_q),
        .deger2_o   (deger2_q),
        .amb_sonuc_i(amb_sonuc),
        .gecersiz_i (gecersiz),
        .sonuc_o    (sonuc_o),
        .gecersiz_o (gecersiz_o)
    );

    buyruk_cozucu cozucu (
        .buyruk_i      (buyruk_q),
        .deger2_i      (deger2_q),
        .islem_o       (islem),
        .ikinci_deger_o(ikinci_deger),
        .gecersiz_o    (gecersiz)
    );

    aritmetik_mantik_birimi #(
        .XLEN(XLEN)
    ) amb (
        .islem_i (islem),
        .deger1_i(deger1_q),
        .deger2_i(ikinci_deger),
        .sonuc_o (amb_sonuc)
    );

endmodule

// ==== include/referans_model.svh ====
// Testbench referans modeli; amb_pkg ve buyruk_pkg import eden test modulunun icine include edilir
`ifndef REFERANS_MODEL_SVH
`define REFERANS_MODEL_SVH

// Ham bit dilimlerinden cozum
function automatic void model_coz(
    input  logic [31:0] b,
    input  logic [31:0] d2,
    output amb_islem_t  islem,
    output logic [31:0] ikinci,
    output logic        gecersiz
);
    logic [6:0] opc;
    logic [2:0] f3;
    logic [6:0] f7;
    opc      = b[6:0];
    f3       = b[14:12];
    f7       = b[31:25];
    islem    = AMB_TOPLAMA;
    ikinci   = d2;
    gecersiz = 1'b0;
    if (opc == OPC_LUI) begin
        islem  = AMB_GECIR;
        ikinci = {b[31:12], 12'h000};
    end else if (opc == OPC_OP || opc == OPC_OP_IMM) begin
        if (opc == OPC_OP_IMM) begin
            ikinci = {{20{b[31]}}, b[31:20]};
        end
        case (f3)
            F3_ADD_SUB: islem = (opc == OPC_OP && f7 == F7_ALT) ? AMB_CIKARMA : AMB_TOPLAMA;
            F3_SLL:     islem = AMB_SLL;
            F3_SLT:     islem = AMB_SLT;
            F3_SLTU:    islem = AMB_SLTU;
            F3_XOR:     islem = AMB_XOR;
            F3_SRL_SRA: islem = (f7 == F7_ALT) ? AMB_SRA : AMB_SRL;
            F3_OR:      islem = AMB_OR;
            default:    islem = AMB_AND;
        endcase
        if (opc == OPC_OP) begin
            gecersiz = !(f7 == F7_TEMEL
                         || (f7 == F7_ALT && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)));
        end else if (f3 == F3_SLL) begin
            gecersiz = (f7 != F7_TEMEL);
        end else if (f3 == F3_SRL_SRA) begin
            gecersiz = !(f7 == F7_TEMEL || f7 == F7_ALT);
        end
    end else begin
        gecersiz = 1'b1;
    end
endfunction

function automatic logic [31:0] model_hesapla(
    input amb_islem_t  islem,
    input logic [31:0] d1,
    input logic [31:0] d2
);
    case (islem)
        AMB_TOPLAMA: return d1 + d2;
        AMB_CIKARMA: return d1 - d2;
        AMB_XOR:     return d1 ^ d2;
        AMB_OR:      return d1 | d2;
        AMB_AND:     return d1 & d2;
        AMB_SLL:     return d1 << d2[4:0];
        AMB_SRL:     return d1 >> d2[4:0];
        // Bosalan ust bitler isaret biti ile dolar
        AMB_SRA:     return (d1 >> d2[4:0]) | ({32{d1[31]}} & ~(32'hffff_ffff >> d2[4:0]));
        // Isaretler farkliysa negatif olan kucuk
        AMB_SLT:     return (d1[31] != d2[31]) ? {31'd0, d1[31]}
                                               : ((d1 < d2) ? 32'd1 : 32'd0);
        AMB_SLTU:    return (d1 < d2) ? 32'd1 : 32'd0;
        AMB_GECIR:   return d2;
        default:     return 32'd0;
    endcase
endfunction

// Gecersiz buyrukta sonuc sifir
function automatic void model_beklenen(
    input  logic [31:0] b,
    input  logic [31:0] d1,
    input  logic [31:0] d2,
    output amb_islem_t  islem,
    output logic [31:0] sonuc,
    output logic        gecersiz
);
    logic [31:0] ikinci;
    model_coz(b, d2, islem, ikinci, gecersiz);
    sonuc = gecersiz ? 32'd0 : model_hesapla(islem, d1, ikinci);
endfunction

`endif

// ==== tb/tb_yurutme_birimi.sv ====
// Yurutme birimi testbench'i; rastgele buyruklari dort fazli el sikisma ile surer, modelle karsilastirir
`timescale 1ns/1ns

module tb_yurutme_birimi import amb_pkg::*, buyruk_pkg::*; ();

    localparam int XLEN        = 32;
    localparam int ISLEM_SAY   = 2000;
    // Bir islem en cok 9 cevrim surer ve 10 pay birakir
    localparam int ZAMAN_ASIMI = ISLEM_SAY * 10;

    logic            clk_i;
    logic            rst_n_i;
    logic            req_i;
    buyruk_t         buyruk_i;
    logic [XLEN-1:0] deger1_i;
    logic [XLEN-1:0] deger2_i;
    logic            ack_o;
    logic [XLEN-1:0] sonuc_o;
    logic            gecersiz_o;

    integer seed;
    int     cevrim = 0;

    `include "referans_model.svh"

    yurutme_birimi #(
        .XLEN(XLEN)
    ) yurutme_birimi_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (req_i),
        .buyruk_i  (buyruk_i),
        .deger1_i  (deger1_i),
        .deger2_i  (deger2_i),
        .ack_o     (ack_o),
        .sonuc_o   (sonuc_o),
        .gecersiz_o(gecersiz_o)
    );

    always #2 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        cevrim <= cevrim + 1;
        if (cevrim >= ZAMAN_ASIMI) begin
            $display("Timeout: the run did not finish within %0d clock cycles", ZAMAN_ASIMI);
            $display("TEST FAIL");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic durdur(input string satir);
        $display("%s", satir);
        $display("TEST FAIL");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic kontrol_sonuc(input logic [XLEN-1:0] gercek, input logic [XLEN-1:0] beklenen,
                                 input string mesaj);
        if (gercek !== beklenen) begin
            durdur($sformatf("MISMATCH at %0t: %s result got %h expected %h",
                             $time, mesaj, gercek, beklenen));
        end
    endtask

    task automatic kontrol_gecersiz(input logic gercek, input logic beklenen, input string mesaj);
        if (gercek !== beklenen) begin
            durdur($sformatf("MISMATCH at %0t: %s illegal flag got %b expected %b",
                             $time, mesaj, gercek, beklenen));
        end
    endtask

    task automatic kontrol_islem(input amb_islem_t gercek, input amb_islem_t beklenen,
                                 input string mesaj);
        if (gercek !== beklenen) begin
            durdur($sformatf("MISMATCH at %0t: %s decoded op got %s expected %s",
                             $time, mesaj, gercek.name(), beklenen.name()));
        end
    endtask

    task automatic kontrol_ack(input logic gercek, input logic beklenen, input string mesaj);
        if (gercek !== beklenen) begin
            durdur($sformatf("MISMATCH at %0t: %s ack got %b expected %b",
                             $time, mesaj, gercek, beklenen));
        end
    endtask

    task automatic kontrol_gecikme(input int gercek, input int beklenen, input string mesaj);
        if (gercek != beklenen) begin
            durdur($sformatf("MISMATCH at %0t: %s took %0d edges expected %0d",
                             $time, mesaj, gercek, beklenen));
        end
    endtask

    // Kose degerleri arada bir
    task automatic rastgele_deger(output logic [31:0] d);
        logic [31:0] r;
        logic [31:0] k;
        r = $random(seed);
        k = $random(seed);
        case (k[2:0])
            3'd0:    d = 32'h0000_0000;
            3'd1:    d = 32'hffff_ffff;
            3'd2:    d = 32'h8000_0000;
            3'd3:    d = 32'h7fff_ffff;
            default: d = r;
        endcase
    endtask

    task automatic uret_buyruk(output logic [31:0] b);
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] sec;
        logic [6:0]  f7;
        logic [2:0]  f3;
        r   = $random(seed);
        s   = $random(seed);
        sec = s % 32'd100;
        f3  = r[14:12];
        if (sec < 32'd40) begin
            f7 = (r[30] && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA)) ? F7_ALT : F7_TEMEL;
            b  = {f7, r[24:15], f3, r[11:7], OPC_OP};
        end else if (sec < 32'd78) begin
            if (f3 == F3_SLL) begin
                f7 = F7_TEMEL;
            end else if (f3 == F3_SRL_SRA) begin
                f7 = r[30] ? F7_ALT : F7_TEMEL;
            end else begin
                f7 = r[31:25];
            end
            b = {f7, r[24:15], f3, r[11:7], OPC_OP_IMM};
        end else if (sec < 32'd85) begin
            b = {r[31:7], OPC_LUI};
        end else if (sec < 32'd92) begin
            b = r;
        end else begin
            // Bit 0 set oldugundan ne TEMEL ne ALT
            f7 = r[31:25] | 7'b000_0001;
            if (s[8]) begin
                b = {f7, r[24:15], f3, r[11:7], OPC_OP};
            end else begin
                f3 = s[9] ? F3_SLL : F3_SRL_SRA;
                b  = {f7, r[24:15], f3, r[11:7], OPC_OP_IMM};
            end
        end
    endtask

    task automatic islem_yap(input logic [31:0] b, input logic [31:0] d1, input logic [31:0] d2,
                             input int bosluk, input int bekleme);
        amb_islem_t  islem_bek;
        logic [31:0] sonuc_bek;
        logic        gecersiz_bek;
        int          kenar;
        string       etiket;
        model_beklenen(b, d1, d2, islem_bek, sonuc_bek, gecersiz_bek);
        etiket = $sformatf("%s word %h", islem_bek.name(), b);
        repeat (bosluk) @(negedge clk_i);
        buyruk_i = b;
        deger1_i = d1;
        deger2_i = d2;
        req_i    = 1'b1;
        kenar    = 0;
        do begin
            @(negedge clk_i);
            kenar++;
        end while (!ack_o);
        kontrol_gecikme(kenar, 2, {etiket, " req to ack"});
        kontrol_sonuc(sonuc_o, sonuc_bek, etiket);
        kontrol_gecersiz(gecersiz_o, gecersiz_bek, etiket);
        if (!gecersiz_bek) begin
            kontrol_islem(yurutme_birimi_i.islem, islem_bek, etiket);
        end
        // Yavas istekci suresince cikislar sabit kalmali
        repeat (bekleme) begin
            @(negedge clk_i);
            kontrol_ack(ack_o, 1'b1, {etiket, " held"});
            kontrol_sonuc(sonuc_o, sonuc_bek, {etiket, " held"});
            kontrol_gecersiz(gecersiz_o, gecersiz_bek, {etiket, " held"});
        end
        req_i    = 1'b0;
        buyruk_i = $random(seed);
        deger1_i = $random(seed);
        deger2_i = $random(seed);
        kenar    = 0;
        do begin
            @(negedge clk_i);
            kenar++;
        end while (ack_o);
        kontrol_gecikme(kenar, 1, {etiket, " req low to ack low"});
    endtask

    initial begin
        logic [31:0] b;
        logic [31:0] d1;
        logic [31:0] d2;
        logic [31:0] r;
        seed     = 32'h50752ba6;
        clk_i    = 1'b0;
        rst_n_i  = 1'b0;
        req_i    = 1'b0;
        buyruk_i = '0;
        deger1_i = '0;
        deger2_i = '0;
        repeat (3) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        kontrol_ack(ack_o, 1'b0, "after reset");
        kontrol_sonuc(sonuc_o, '0, "after reset");
        kontrol_gecersiz(gecersiz_o, 1'b0, "after reset");

        // Tum gruplardan tasan elde ve odunc, isaret farki
        islem_yap({F7_TEMEL, 5'd3, 5'd2, F3_ADD_SUB, 5'd1, OPC_OP}, 32'hffff_ffff, 32'd1, 0, 0);
        islem_yap({F7_ALT, 5'd3, 5'd2, F3_ADD_SUB, 5'd1, OPC_OP}, 32'd0, 32'd1, 0, 1);
        islem_yap({F7_TEMEL, 5'd3, 5'd2, F3_SLT, 5'd1, OPC_OP}, 32'h8000_0000, 32'd1, 1, 0);
        islem_yap({F7_TEMEL, 5'd3, 5'd2, F3_SLTU, 5'd1, OPC_OP}, 32'h8000_0000, 32'd1, 0, 2);
        islem_yap({F7_ALT, 5'd31, 5'd2, F3_SRL_SRA, 5'd1, OPC_OP_IMM}, 32'h8000_0000, 32'd0, 0, 0);
        islem_yap({12'hfff, 5'd2, F3_ADD_SUB, 5'd1, OPC_OP_IMM}, 32'd0, 32'd0, 2, 3);

        for (int i = 0; i < ISLEM_SAY; i++) begin
            uret_buyruk(b);
            rastgele_deger(d1);
            rastgele_deger(d2);
            r = $random(seed);
            islem_yap(b, d1, d2, int'(r[1:0]), int'(r[3:2]));
        end

        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+include
src/amb_pkg.sv
src/buyruk_pkg.sv
src/carry_lookahead_toplayici.sv
src/aritmetik_mantik_birimi.sv
src/buyruk_cozucu.sv
src/yurutme_denetleyici.sv
src/yurutme_birimi.sv
tb/tb_yurutme_birimi.sv

// ==== Makefile ====
TOP = tb_yurutme_birimi

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f list.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

.PHONY: sim clean
